// ==== adc_pkg.sv ====
// ADC and I2C bus constants
// shared by the I2C reader and the bus model of the ADC
package adc_pkg;

	// 7-bit slave address of the ADC
	localparam logic [6:0] ADC_DEV_ADDR = 7'h48;

	// control byte written before every read
	// analog output enabled, single ended inputs, channel 0
	localparam logic [7:0] ADC_CTRL_REG = 8'h40;

	// sys_clk cycles per quarter of an SCL period
	localparam int SCL_QUARTER = 25;

	// one ADC conversion result
	localparam int SAMPLE_W = 8;

endpackage

// ==== disp_pkg.sv ====
// panel constants
// digit codes, segment patterns, scan and key debounce timing
package disp_pkg;

	localparam int DIGIT_NUM    = 8;
	localparam int DIGIT_CODE_W = 5;

	// codes 0 to 15 are the hex glyphs
	localparam logic [DIGIT_CODE_W-1:0] GLYPH_BLANK = 5'd16;
	localparam logic [DIGIT_CODE_W-1:0] GLYPH_H     = 5'd18;
	// decimal marker is the plain "d" glyph
	localparam logic [DIGIT_CODE_W-1:0] GLYPH_D     = 5'd13;

	// active low, bit 0 is segment a, bit 7 the decimal point
	localparam logic [7:0] SEG_TABLE [2**DIGIT_CODE_W] = '{
		// 0 to 7
		8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
		// 8 to F
		8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e,
		// blank, spare, H, spare
		8'hff, 8'hff, 8'h89, 8'hff,
		// unused codes stay dark
		8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff,
		8'hff, 8'hff, 8'hff, 8'hff, 8'hff, 8'hff
	};

	// cycles each digit stays selected
	localparam int SCAN_CYCLES = 64;

	localparam int KEY_NUM         = 2;
	localparam int KEY_FREEZE      = 0;
	localparam int KEY_MODE        = 1;
	localparam int DEBOUNCE_CYCLES = 400;

endpackage

// ==== i2c_adc_reader.sv ====
`timescale 1ns/1ns
// I2C master for the ADC
// loops a register read: control byte write, repeated START, one byte read,
// and strobes sample_vld for every read in which all ACKs were seen
module i2c_adc_reader (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	output logic                         scl,
	inout  wire                          sda,
	output logic [adc_pkg::SAMPLE_W-1:0] sample,
	output logic                         sample_vld
);

	typedef enum logic [3:0] {
		S_IDLE, S_START, S_ADDR_W, S_ACK_ADDR_W,
		S_CTRL, S_ACK_CTRL, S_RSTART, S_ADDR_R,
		S_ACK_ADDR_R, S_DATA, S_NACK, S_STOP
	} state_t;

	state_t                                  state;
	state_t                                  state_nxt;
	logic [$clog2(adc_pkg::SCL_QUARTER)-1:0] qcnt;
	logic [1:0]                              phase;
	logic [2:0]                              bit_cnt;
	logic [1:0]                              sda_sync;
	logic [adc_pkg::SAMPLE_W-1:0]            rx_shift;
	logic [7:0]                              tx_byte;
	logic                                    ack_err;
	logic                                    sda_low;
	logic                                    sda_low_nxt;
	logic                                    scl_nxt;
	logic                                    bit_end;
	logic                                    sample_pt;
	logic                                    byte_state;
	logic                                    ack_state;

	// open drain, the board pulls sda up
	assign sda = sda_low ? 1'b0 : 1'bz;

	assign bit_end   = (qcnt == adc_pkg::SCL_QUARTER - 1) && (phase == 2'd3);
	// middle of the scl high time
	assign sample_pt = (qcnt == '0) && (phase == 2'd2);

	assign byte_state = (state == S_ADDR_W) || (state == S_CTRL) ||
		(state == S_ADDR_R) || (state == S_DATA);
	assign ack_state  = (state == S_ACK_ADDR_W) || (state == S_ACK_CTRL) ||
		(state == S_ACK_ADDR_R);

	always_comb begin
		case (state)
			S_CTRL:   tx_byte = adc_pkg::ADC_CTRL_REG;
			S_ADDR_R: tx_byte = {adc_pkg::ADC_DEV_ADDR, 1'b1};
			default:  tx_byte = {adc_pkg::ADC_DEV_ADDR, 1'b0};
		endcase
	end

	// one step per bit time, a missing ACK goes straight to STOP
	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE:       state_nxt = S_START;
			S_START:      state_nxt = S_ADDR_W;
			S_ADDR_W:     if (bit_cnt == 3'd7) state_nxt = S_ACK_ADDR_W;
			S_ACK_ADDR_W: state_nxt = ack_err ? S_STOP : S_CTRL;
			S_CTRL:       if (bit_cnt == 3'd7) state_nxt = S_ACK_CTRL;
			S_ACK_CTRL:   state_nxt = ack_err ? S_STOP : S_RSTART;
			S_RSTART:     state_nxt = S_ADDR_R;
			S_ADDR_R:     if (bit_cnt == 3'd7) state_nxt = S_ACK_ADDR_R;
			S_ACK_ADDR_R: state_nxt = ack_err ? S_STOP : S_DATA;
			S_DATA:       if (bit_cnt == 3'd7) state_nxt = S_NACK;
			S_NACK:       state_nxt = S_STOP;
			S_STOP:       state_nxt = S_IDLE;
			default:      state_nxt = S_IDLE;
		endcase
	end

	// bus levels per quarter, data moves only while scl is low
	always_comb begin
		scl_nxt     = phase[1] ^ phase[0];
		sda_low_nxt = 1'b0;
		case (state)
			S_IDLE: scl_nxt = 1'b1;
			S_START, S_RSTART: begin
				// a first START comes from idle with scl still high
				if (state == S_START && phase == 2'd0)
					scl_nxt = 1'b1;
				sda_low_nxt = phase[1];
			end
			S_ADDR_W, S_CTRL, S_ADDR_R: sda_low_nxt = ~tx_byte[3'd7 - bit_cnt];
			S_STOP: begin
				scl_nxt     = (phase != 2'd0);
				sda_low_nxt = ~phase[1];
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= S_IDLE;
			qcnt       <= '0;
			phase      <= 2'd0;
			bit_cnt    <= 3'd0;
			sda_sync   <= 2'b11;
			scl        <= 1'b1;
			sda_low    <= 1'b0;
			ack_err    <= 1'b0;
			sample_vld <= 1'b0;
		end else begin
			sda_sync <= {sda_sync[0], sda};
			scl      <= scl_nxt;
			sda_low  <= sda_low_nxt;
			if (qcnt == adc_pkg::SCL_QUARTER - 1) begin
				qcnt  <= '0;
				phase <= phase + 2'd1;
			end else begin
				qcnt <= qcnt + 1'b1;
			end
			if (bit_end) begin
				state   <= state_nxt;
				bit_cnt <= byte_state ? bit_cnt + 3'd1 : 3'd0;
			end
			if (bit_end && state == S_IDLE)
				ack_err <= 1'b0;
			else if (sample_pt && ack_state && sda_sync[1])
				ack_err <= 1'b1;
			sample_vld <= bit_end && (state == S_STOP) && !ack_err;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sample_pt && state == S_DATA)
			rx_shift <= {rx_shift[adc_pkg::SAMPLE_W-2:0], sda_sync[1]};
		if (bit_end && state == S_STOP && !ack_err)
			sample <= rx_shift;
	end

endmodule

// ==== key_debounce.sv ====
`timescale 1ns/1ns
// key debouncer
// active low keys in, one-cycle press pulse out per accepted press
module key_debounce (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [disp_pkg::KEY_NUM-1:0] key_in,
	output logic [disp_pkg::KEY_NUM-1:0] key_press
);

	logic [disp_pkg::KEY_NUM-1:0]                     sync_a;
	logic [disp_pkg::KEY_NUM-1:0]                     sync_b;
	logic [disp_pkg::KEY_NUM-1:0]                     level;
	logic [$clog2(disp_pkg::DEBOUNCE_CYCLES)-1:0]     cnt [disp_pkg::KEY_NUM];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_a    <= '1;
			sync_b    <= '1;
			level     <= '1;
			key_press <= '0;
			for (int i = 0; i < disp_pkg::KEY_NUM; i++)
				cnt[i] <= '0;
		end else begin
			sync_a <= key_in;
			sync_b <= sync_a;
			for (int i = 0; i < disp_pkg::KEY_NUM; i++) begin
				key_press[i] <= 1'b0;
				// any bounce back to the old level restarts the count
				if (sync_b[i] == level[i]) begin
					cnt[i] <= '0;
				end else if (cnt[i] == disp_pkg::DEBOUNCE_CYCLES - 1) begin
					cnt[i]       <= '0;
					level[i]     <= sync_b[i];
					// pressed means low
					key_press[i] <= ~sync_b[i];
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// ==== adc_digit_format.sv ====
`timescale 1ns/1ns
// display formatter
// freezes or passes the ADC sample and builds eight digit codes,
// decimal with blanked leading zeros or two hex nibbles
module adc_digit_format (
	input  logic                                                    sys_clk,
	input  logic                                                    sys_rst_n,
	input  logic [adc_pkg::SAMPLE_W-1:0]                            sample,
	input  logic                                                    sample_vld,
	input  logic [disp_pkg::KEY_NUM-1:0]                            key_press,
	output logic [7:0]                                              shown_sample,
	output logic [disp_pkg::DIGIT_NUM*disp_pkg::DIGIT_CODE_W-1:0]   digit_codes
);

	logic       frozen;
	logic       frozen_nxt;
	logic       hex_mode;
	logic       hex_mode_nxt;
	logic [7:0] shown_nxt;

	function automatic logic [disp_pkg::DIGIT_NUM*disp_pkg::DIGIT_CODE_W-1:0] build_codes(
		input logic [7:0] val,
		input logic       hex
	);
		logic [disp_pkg::DIGIT_NUM-1:0][disp_pkg::DIGIT_CODE_W-1:0] codes;
		logic [7:0]                                                 hun;
		logic [7:0]                                                 ten;
		logic [7:0]                                                 one;
		hun   = val / 8'd100;
		ten   = (val / 8'd10) % 8'd10;
		one   = val % 8'd10;
		codes = {disp_pkg::DIGIT_NUM{disp_pkg::GLYPH_BLANK}};
		if (hex) begin
			codes[disp_pkg::DIGIT_NUM-1] = disp_pkg::GLYPH_H;
			codes[1] = {1'b0, val[7:4]};
			codes[0] = {1'b0, val[3:0]};
		end else begin
			codes[disp_pkg::DIGIT_NUM-1] = disp_pkg::GLYPH_D;
			// units always show, higher digits only when nonzero ahead
			codes[0] = {1'b0, one[3:0]};
			if (val >= 8'd10)
				codes[1] = {1'b0, ten[3:0]};
			if (val >= 8'd100)
				codes[2] = {1'b0, hun[3:0]};
		end
		return codes;
	endfunction

	always_comb begin
		frozen_nxt   = frozen ^ key_press[disp_pkg::KEY_FREEZE];
		hex_mode_nxt = hex_mode ^ key_press[disp_pkg::KEY_MODE];
		// samples arriving while frozen are dropped
		shown_nxt    = (sample_vld && !frozen) ? sample : shown_sample;
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			frozen       <= 1'b0;
			hex_mode     <= 1'b0;
			shown_sample <= 8'd0;
			digit_codes  <= build_codes(8'd0, 1'b0);
		end else begin
			frozen       <= frozen_nxt;
			hex_mode     <= hex_mode_nxt;
			shown_sample <= shown_nxt;
			digit_codes  <= build_codes(shown_nxt, hex_mode_nxt);
		end
	end

endmodule

// ==== seg_scan.sv ====
`timescale 1ns/1ns
// seven-segment scanner
// cycles through the digits and drives active low segments and selects
module seg_scan (
	input  logic                                                  sys_clk,
	input  logic                                                  sys_rst_n,
	input  logic [disp_pkg::DIGIT_NUM*disp_pkg::DIGIT_CODE_W-1:0] digit_codes,
	output logic [7:0]                                            seg_number,
	output logic [disp_pkg::DIGIT_NUM-1:0]                        seg_choice
);

	logic [$clog2(disp_pkg::SCAN_CYCLES)-1:0] dwell;
	logic [$clog2(disp_pkg::DIGIT_NUM)-1:0]   idx;
	logic [disp_pkg::DIGIT_CODE_W-1:0]        cur_code;
	logic [disp_pkg::DIGIT_NUM-1:0]           sel_nxt;

	assign cur_code = digit_codes[idx*disp_pkg::DIGIT_CODE_W +: disp_pkg::DIGIT_CODE_W];

	// one cold select of the current digit
	always_comb begin
		for (int i = 0; i < disp_pkg::DIGIT_NUM; i++)
			sel_nxt[i] = (idx != i);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dwell      <= '0;
			idx        <= '0;
			seg_number <= 8'hff;
			seg_choice <= {{(disp_pkg::DIGIT_NUM-1){1'b1}}, 1'b0};
		end else begin
			if (dwell == disp_pkg::SCAN_CYCLES - 1) begin
				dwell <= '0;
				if (idx == disp_pkg::DIGIT_NUM - 1)
					idx <= '0;
				else
					idx <= idx + 1'b1;
			end else begin
				dwell <= dwell + 1'b1;
			end
			// pattern and select move together
			seg_number <= disp_pkg::SEG_TABLE[cur_code];
			seg_choice <= sel_nxt;
		end
	end

endmodule

// ==== adc_display_top.sv ====
`timescale 1ns/1ns
// ADC readout panel
// I2C sample in, decimal or hex on the eight-digit display, raw byte on the LEDs
module adc_display_top (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic [disp_pkg::KEY_NUM-1:0] key_in,
	output logic [7:0]                   led,
	output logic [7:0]                   seg_number,
	output logic [7:0]                   seg_choice,
	output logic                         scl,
	inout  wire                          sda
);

	logic [adc_pkg::SAMPLE_W-1:0]                             sample;
	logic                                                     sample_vld;
	logic [disp_pkg::KEY_NUM-1:0]                             key_press;
	logic [7:0]                                               shown_sample;
	logic [disp_pkg::DIGIT_NUM*disp_pkg::DIGIT_CODE_W-1:0]    digit_codes;

	// LEDs follow the shown byte, frozen or not
	assign led = shown_sample;

	i2c_adc_reader u_reader (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda        (sda),
		.sample     (sample),
		.sample_vld (sample_vld)
	);

	key_debounce u_keys (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_press (key_press)
	);

	adc_digit_format u_format (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sample       (sample),
		.sample_vld   (sample_vld),
		.key_press    (key_press),
		.shown_sample (shown_sample),
		.digit_codes  (digit_codes)
	);

	seg_scan u_scan (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.digit_codes (digit_codes),
		.seg_number  (seg_number),
		.seg_choice  (seg_choice)
	);

endmodule

// ==== i2c_adc_model.sv ====
`timescale 1ns/1ns
// behavioral ADC on the I2C bus
// acks its own register read, returns adc_byte and checks the frame format
module i2c_adc_model (
	input  logic       scl,
	inout  wire        sda,
	input  logic [7:0] adc_byte,
	output int         xfer_cnt,
	output int         err_cnt
);

	logic sda_low;

	assign sda = sda_low ? 1'b0 : 1'bz;

	task automatic complain(input string what, input logic [7:0] val);
		$display("I2C model at %0t: %s (byte %02h)", $time, what, val);
		err_cnt++;
	endtask

	// kind 0 is a plain bit, 1 a START, 2 a STOP
	task automatic read_bit(output logic val, output int kind);
		@(posedge scl);
		val = sda;
		@(negedge scl or sda);
		kind = (scl === 1'b0) ? 0 : ((sda === 1'b0) ? 1 : 2);
	endtask

	task automatic read_byte(output logic [7:0] val, output int kind);
		logic bit_val;
		val  = 8'h00;
		kind = 0;
		for (int i = 0; i < 8 && kind == 0; i++) begin
			read_bit(bit_val, kind);
			val = {val[6:0], bit_val};
		end
	endtask

	task automatic give_ack();
		sda_low = 1'b1;
		@(posedge scl);
		@(negedge scl);
		sda_low = 1'b0;
	endtask

	task automatic serve_frame();
		logic [7:0] rx;
		logic [7:0] tx;
		logic       bit_val;
		int         kind;
		read_byte(rx, kind);
		if (kind != 0 || rx !== {adc_pkg::ADC_DEV_ADDR, 1'b0}) begin
			complain("wrong device address or write bit after START", rx);
			return;
		end
		give_ack();
		read_byte(rx, kind);
		if (kind != 0 || rx !== adc_pkg::ADC_CTRL_REG) begin
			complain("wrong control byte", rx);
			return;
		end
		give_ack();
		read_bit(bit_val, kind);
		if (kind != 1) begin
			complain("missing repeated START after the control byte", 8'h00);
			return;
		end
		read_byte(rx, kind);
		if (kind != 0 || rx[7:1] !== adc_pkg::ADC_DEV_ADDR || rx[0] !== 1'b1) begin
			complain("wrong device address or read bit after repeated START", rx);
			return;
		end
		// ack, then the sample msb first
		tx      = adc_byte;
		sda_low = 1'b1;
		@(posedge scl);
		for (int i = 7; i >= 0; i--) begin
			@(negedge scl);
			sda_low = ~tx[i];
			@(posedge scl);
		end
		@(negedge scl);
		sda_low = 1'b0;
		read_bit(bit_val, kind);
		if (bit_val !== 1'b1)
			complain("master sent ACK instead of NACK on the data byte", tx);
		read_bit(bit_val, kind);
		if (kind != 2)
			complain("missing STOP at the end of the read", tx);
		xfer_cnt++;
	endtask

	initial begin
		sda_low  = 1'b0;
		xfer_cnt = 0;
		err_cnt  = 0;
		forever begin
			@(negedge sda);
			if (scl === 1'b1)
				serve_frame();
		end
	end

endmodule

// ==== adc_display_assert.sv ====
`timescale 1ns/1ns
// concurrent checks on the panel top
// digit select, sample strobe, open-drain sda and the shown byte
module adc_display_assert (
	input logic       sys_clk,
	input logic       sys_rst_n,
	input logic [7:0] seg_choice,
	input logic       sample_vld,
	input logic [7:0] shown_sample,
	input logic       rd_sda_low,
	input logic       sda
);

	int fail_cnt = 0;

	one_digit_selected: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice))
		else begin
			fail_cnt++;
			$error("digit select is not one-cold: %b", seg_choice);
		end

	vld_single_cycle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_vld |=> !sample_vld)
		else begin
			fail_cnt++;
			$error("sample_vld stayed high for more than one cycle");
		end

	// a high drive against a slave ACK would resolve to x
	sda_open_drain: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!$isunknown(sda) && (!rd_sda_low || sda == 1'b0))
		else begin
			fail_cnt++;
			$error("sda is not open drain: sda %b, reader pulls low %b", sda, rd_sda_low);
		end

	shown_after_vld: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!$stable(shown_sample) |-> $past(sample_vld))
		else begin
			fail_cnt++;
			$error("shown_sample changed without a sample_vld the cycle before");
		end

endmodule

// ==== tb_adc_display.sv ====
`timescale 1ns/1ns
// testbench for the ADC readout panel
// replays bytes and key presses, decodes the scanned display and checks it
module tb_adc_display;

	localparam int STEP_NUM       = 12;
	localparam int SCAN_TOTAL     = disp_pkg::DIGIT_NUM * disp_pkg::SCAN_CYCLES;
	// 39 bit times of frame plus the idle bit
	localparam int XFER_CYCLES    = 40 * 4 * adc_pkg::SCL_QUARTER;
	localparam int TIMEOUT_CYCLES = STEP_NUM *
		(XFER_CYCLES + 4 * disp_pkg::DEBOUNCE_CYCLES + 2 * SCAN_TOTAL) * 2;

	logic                         sys_clk;
	logic                         sys_rst_n;
	logic [disp_pkg::KEY_NUM-1:0] key_in;
	logic [7:0]                   led;
	logic [7:0]                   seg_number;
	logic [7:0]                   seg_choice;
	logic                         scl;
	wire                          sda;
	logic [7:0]                   adc_byte;
	int                           xfer_cnt;
	int                           model_err;
	logic [19:0]                  steps [STEP_NUM];
	logic [7:0]                   shown_seg [disp_pkg::DIGIT_NUM];
	logic                         hex_mode;
	int                           err_cnt;
	int                           failed_tests;
	int                           errs_before;
	int                           seed;
	int                           key_code;
	logic [7:0]                   stim_byte;
	logic [7:0]                   exp_led;

	pullup (sda);

	adc_display_top dut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.led        (led),
		.seg_number (seg_number),
		.seg_choice (seg_choice),
		.scl        (scl),
		.sda        (sda)
	);

	i2c_adc_model adc_slave (
		.scl      (scl),
		.sda      (sda),
		.adc_byte (adc_byte),
		.xfer_cnt (xfer_cnt),
		.err_cnt  (model_err)
	);

	bind adc_display_top adc_display_assert u_assert (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.seg_choice   (seg_choice),
		.sample_vld   (sample_vld),
		.shown_sample (shown_sample),
		.rd_sda_low   (u_reader.sda_low),
		.sda          (sda)
	);

	initial sys_clk = 1'b0;
	always #20 sys_clk = ~sys_clk;

	function automatic int total_errors();
		return err_cnt + model_err + dut.u_assert.fail_cnt;
	endfunction

	// glyph code a digit position should hold
	function automatic int glyph_for(int pos, logic [7:0] val, logic hex);
		int rest;
		if (pos == disp_pkg::DIGIT_NUM - 1)
			return hex ? disp_pkg::GLYPH_H : disp_pkg::GLYPH_D;
		if (hex)
			return (pos == 0) ? val % 16 : ((pos == 1) ? val / 16 : disp_pkg::GLYPH_BLANK);
		if (pos > 2)
			return disp_pkg::GLYPH_BLANK;
		rest = val;
		for (int i = 0; i < pos; i++)
			rest = rest / 10;
		// leading zeros dark, units always lit
		if (pos > 0 && rest == 0)
			return disp_pkg::GLYPH_BLANK;
		return rest % 10;
	endfunction

	task automatic wait_xfers(input int n);
		int target;
		target = xfer_cnt + n;
		while (xfer_cnt < target)
			@(posedge sys_clk);
	endtask

	// bounce edges, then settle on lvl and hold it
	task automatic bounce_to(input int k, input logic lvl);
		for (int i = 0; i < 8; i++) begin
			@(posedge sys_clk);
			key_in[k] <= (i % 2 == 0) ? lvl : ~lvl;
			repeat (1 + $urandom % 30) @(posedge sys_clk);
		end
		@(posedge sys_clk);
		key_in[k] <= lvl;
		repeat (2 * disp_pkg::DEBOUNCE_CYCLES) @(posedge sys_clk);
	endtask

	task automatic capture_display();
		logic [7:0] seen;
		int         waited;
		seen   = 8'h00;
		waited = 0;
		while (seen != 8'hff && waited < 2 * SCAN_TOTAL) begin
			@(negedge sys_clk);
			waited++;
			for (int i = 0; i < disp_pkg::DIGIT_NUM; i++) begin
				if (seg_choice == ~(8'h01 << i)) begin
					shown_seg[i] = seg_number;
					seen[i]      = 1'b1;
				end
			end
		end
		if (seen != 8'hff) begin
			$display("display scan did not select every digit within two scans");
			err_cnt++;
		end
	endtask

	task automatic check_led(input logic [7:0] want);
		if (led !== want) begin
			$display("error at %0t: led = %02h, expected %02h", $time, led, want);
			err_cnt++;
		end
	endtask

	task automatic check_display(input logic [7:0] val, input logic hex);
		logic [7:0] want;
		for (int pos = 0; pos < disp_pkg::DIGIT_NUM; pos++) begin
			want = disp_pkg::SEG_TABLE[glyph_for(pos, val, hex)];
			if (shown_seg[pos] !== want) begin
				$display("error at %0t: seg_number digit %0d = %02h, expected %02h",
					$time, pos, shown_seg[pos], want);
				err_cnt++;
			end
		end
	endtask

	task automatic close_test(input string name);
		if (total_errors() == errs_before) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: failed", name);
			failed_tests++;
		end
		errs_before = total_errors();
	endtask

	// run limit
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge sys_clk);
		$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		seed         = $urandom(32'h46c5_3230);
		sys_rst_n    = 1'b0;
		key_in       = '1;
		adc_byte     = 8'h00;
		hex_mode     = 1'b0;
		err_cnt      = 0;
		failed_tests = 0;
		errs_before  = 0;
		$readmemh("adc_stimulus.txt", steps);
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		// idle bus and blank decimal display before the first read
		@(negedge sys_clk);
		if (scl !== 1'b1) begin
			$display("error at %0t: scl = %b, expected 1", $time, scl);
			err_cnt++;
		end
		capture_display();
		if (xfer_cnt != 0) begin
			$display("first transaction finished before the reset check was done");
			err_cnt++;
		end
		check_led(8'h00);
		check_display(8'h00, 1'b0);
		close_test("after reset");

		for (int s = 0; s < STEP_NUM; s++) begin
			key_code  = steps[s][19:16];
			stim_byte = steps[s][15:8];
			exp_led   = steps[s][7:0];
			if (key_code != 0) begin
				bounce_to(key_code - 1, 1'b0);
				bounce_to(key_code - 1, 1'b1);
				if (key_code - 1 == disp_pkg::KEY_MODE)
					hex_mode = ~hex_mode;
			end
			@(posedge sys_clk);
			adc_byte <= stim_byte;
			// a read already under way may still return the old byte
			wait_xfers(2);
			repeat (SCAN_TOTAL) @(posedge sys_clk);
			capture_display();
			check_led(exp_led);
			check_display(exp_led, hex_mode);
			close_test($sformatf("step %0d, key %0d, byte %02h", s, key_code, stim_byte));
		end

		$display("%0d tests run, %0d failed, %0d errors",
			STEP_NUM + 1, failed_tests, total_errors());
		if (total_errors() == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== adc_stimulus.txt ====
// one step per line: key to press first (0 none, 1 freeze key, 2 mode key),
// byte the ADC model returns, expected led value after the step
0_00_00
0_07_07
0_0a_0a
0_63_63
0_64_64
0_ff_ff
2_a5_a5
2_3c_3c
1_81_3c
0_42_3c
1_c8_c8
2_09_09

// ==== all.f ====
adc_pkg.sv
disp_pkg.sv
i2c_adc_reader.sv
key_debounce.sv
adc_digit_format.sv
seg_scan.sv
adc_display_top.sv
i2c_adc_model.sv
adc_display_assert.sv
tb_adc_display.sv
